// ==== sim.f ====
source/rv_pkg.sv
source/id_ex_if.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_id_ex.sv
source/rv_execute.sv
source/rv_core_top.sv
test/tb_clock_gen.sv
test/tb_rv_core.sv

// ==== source/id_ex_if.sv ====
`timescale 1ns/1ps

interface id_ex_if #(
    parameter int XLEN = 64
) ();

    logic                valid;
    rv_pkg::alu_op_e     alu_op;
    rv_pkg::br_op_e      br_op;
    rv_pkg::wb_sel_e     wb_sel;
    logic                sel_imm;  // operand b from imm
    logic                sel_pc;   // operand a from pc
    logic [4:0]          rd;
    logic                wr_en;
    logic [XLEN-1:0]     rs1_val;
    logic [XLEN-1:0]     rs2_val;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     pc;

    modport dec_mp (
        output valid, alu_op, br_op, wb_sel, sel_imm, sel_pc, rd, wr_en,
               rs1_val, rs2_val, imm, pc
    );

    modport reg_in_mp (
        input valid, alu_op, br_op, wb_sel, sel_imm, sel_pc, rd, wr_en,
              rs1_val, rs2_val, imm, pc
    );

    modport reg_out_mp (
        output valid, alu_op, br_op, wb_sel, sel_imm, sel_pc, rd, wr_en,
               rs1_val, rs2_val, imm, pc
    );

    modport ex_mp (
        input valid, alu_op, br_op, wb_sel, sel_imm, sel_pc, rd, wr_en,
              rs1_val, rs2_val, imm, pc
    );

endinterface

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic [XLEN-1:0] pc_i,
    output logic            redirect_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output logic            wb_en_o,
    output logic [4:0]      wb_addr_o,
    output logic [XLEN-1:0] wb_data_o
);

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            bubble;

    id_ex_if #(.XLEN(XLEN)) dec_bus ();
    id_ex_if #(.XLEN(XLEN)) ex_bus ();

    rv_regfile #(.XLEN(XLEN)) i_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (wb_en_o),
        .wr_addr_i  (wb_addr_o),
        .wr_data_i  (wb_data_o)
    );

    rv_decode #(.XLEN(XLEN)) i_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .wb_en_i       (wb_en_o),
        .wb_addr_i     (wb_addr_o),
        .wb_data_i     (wb_data_o),
        .bubble_o      (bubble),
        .dec           (dec_bus.dec_mp)
    );

    rv_id_ex #(.XLEN(XLEN)) i_id_ex (
        .clk      (clk),
        .reset_i  (reset_i),
        .bubble_i (bubble),
        .flush_i  (redirect_o),  // squash the younger slot
        .d_in     (dec_bus.reg_in_mp),
        .d_out    (ex_bus.reg_out_mp)
    );

    rv_execute #(.XLEN(XLEN)) i_execute (
        .ex            (ex_bus.ex_mp),
        .flush_o       (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_en_o       (wb_en_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode #(
    parameter int XLEN = 64
) (
    input  logic            instr_valid_i,
    input  rv_pkg::instr_u  instr_i,
    input  logic [XLEN-1:0] pc_i,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  logic            wb_en_i,
    input  logic [4:0]      wb_addr_i,
    input  logic [XLEN-1:0] wb_data_i,
    output logic            bubble_o,
    id_ex_if.dec_mp         dec
);

    logic               supported;
    logic signed [31:0] imm_i;
    logic signed [31:0] imm_b;
    logic signed [31:0] imm_j;
    logic signed [31:0] imm_u;
    logic signed [31:0] imm_sel;

    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;

    assign imm_i = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
    assign imm_b = {{19{instr_i.r.funct7[6]}}, instr_i.r.funct7[6], instr_i.r.rd[0],
                    instr_i.r.funct7[5:0], instr_i.r.rd[4:1], 1'b0};
    assign imm_j = {{11{instr_i.i.imm12[11]}}, instr_i.i.imm12[11], instr_i.i.rs1,
                    instr_i.i.funct3, instr_i.i.imm12[0], instr_i.i.imm12[10:1], 1'b0};
    assign imm_u = {instr_i.i.imm12, instr_i.i.rs1, instr_i.i.funct3, 12'b0};

    // bypass from the instruction now in execute
    assign dec.rs1_val = (wb_en_i && (wb_addr_i == rs1_addr_o) && (rs1_addr_o != 5'd0))
                         ? wb_data_i : rs1_data_i;
    assign dec.rs2_val = (wb_en_i && (wb_addr_i == rs2_addr_o) && (rs2_addr_o != 5'd0))
                         ? wb_data_i : rs2_data_i;

    always_comb begin
        supported   = 1'b0;
        dec.alu_op  = rv_pkg::alu_add;
        dec.br_op   = rv_pkg::br_none;
        dec.wb_sel  = rv_pkg::wb_alu;
        dec.sel_imm = 1'b0;
        dec.sel_pc  = 1'b0;
        dec.wr_en   = 1'b0;
        imm_sel     = imm_i;
        case (instr_i.r.opcode)
            rv_pkg::op_imm: begin
                supported   = 1'b1;
                dec.sel_imm = 1'b1;
                dec.wr_en   = 1'b1;
                case (instr_i.i.funct3)
                    rv_pkg::f3_add_sub: dec.alu_op = rv_pkg::alu_add;
                    rv_pkg::f3_xor:     dec.alu_op = rv_pkg::alu_xor;
                    rv_pkg::f3_or:      dec.alu_op = rv_pkg::alu_or;
                    rv_pkg::f3_and:     dec.alu_op = rv_pkg::alu_and;
                    default:            supported  = 1'b0;  // shifts, slti
                endcase
            end
            rv_pkg::op: begin
                dec.wr_en = 1'b1;
                supported = (instr_i.r.funct7 == rv_pkg::f7_base);
                case (instr_i.r.funct3)
                    rv_pkg::f3_add_sub: begin
                        if (instr_i.r.funct7 == rv_pkg::f7_alt) begin
                            dec.alu_op = rv_pkg::alu_sub;
                            supported  = 1'b1;
                        end
                    end
                    rv_pkg::f3_xor: dec.alu_op = rv_pkg::alu_xor;
                    rv_pkg::f3_or:  dec.alu_op = rv_pkg::alu_or;
                    rv_pkg::f3_and: dec.alu_op = rv_pkg::alu_and;
                    default:        supported  = 1'b0;
                endcase
            end
            rv_pkg::lui: begin
                supported   = 1'b1;
                dec.alu_op  = rv_pkg::alu_pass_b;
                dec.sel_imm = 1'b1;
                dec.wr_en   = 1'b1;
                imm_sel     = imm_u;
            end
            rv_pkg::jal: begin
                supported   = 1'b1;
                dec.sel_pc  = 1'b1;  // alu gives pc + imm
                dec.sel_imm = 1'b1;
                dec.br_op   = rv_pkg::br_jump;
                dec.wb_sel  = rv_pkg::wb_link;
                dec.wr_en   = 1'b1;
                imm_sel     = imm_j;
            end
            rv_pkg::jalr: begin
                supported   = (instr_i.i.funct3 == 3'b000);
                dec.sel_imm = 1'b1;  // alu gives rs1 + imm
                dec.br_op   = rv_pkg::br_jump;
                dec.wb_sel  = rv_pkg::wb_link;
                dec.wr_en   = 1'b1;
            end
            rv_pkg::branch: begin
                supported = 1'b1;
                imm_sel   = imm_b;
                case (instr_i.r.funct3)
                    rv_pkg::f3_beq: dec.br_op = rv_pkg::br_beq;
                    rv_pkg::f3_bne: dec.br_op = rv_pkg::br_bne;
                    default:        supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    assign dec.imm   = XLEN'(imm_sel);  // sign extends
    assign dec.rd    = instr_i.r.rd;
    assign dec.pc    = pc_i;
    assign dec.valid = instr_valid_i && supported;
    assign bubble_o  = !dec.valid;

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute #(
    parameter int XLEN = 64
) (
    id_ex_if.ex_mp          ex,
    output logic            flush_o,
    output logic [XLEN-1:0] redirect_pc_o,
    output logic            wb_en_o,
    output logic [4:0]      wb_addr_o,
    output logic [XLEN-1:0] wb_data_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] link;
    logic            equal;
    logic            taken;

    assign op_a = ex.sel_pc ? ex.pc : ex.rs1_val;
    assign op_b = ex.sel_imm ? ex.imm : ex.rs2_val;

    always_comb begin
        case (ex.alu_op)
            rv_pkg::alu_add:    alu_res = op_a + op_b;
            rv_pkg::alu_sub:    alu_res = op_a - op_b;
            rv_pkg::alu_and:    alu_res = op_a & op_b;
            rv_pkg::alu_or:     alu_res = op_a | op_b;
            rv_pkg::alu_xor:    alu_res = op_a ^ op_b;
            rv_pkg::alu_pass_b: alu_res = op_b;
            default:            alu_res = op_a + op_b;
        endcase
    end

    assign equal = (ex.rs1_val == ex.rs2_val);

    always_comb begin
        case (ex.br_op)
            rv_pkg::br_beq:  taken = equal;
            rv_pkg::br_bne:  taken = !equal;
            rv_pkg::br_jump: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign pc_imm = ex.pc + ex.imm;
    assign link   = ex.pc + XLEN'(4);

    // jalr target comes out of the alu, low bit dropped
    always_comb begin
        if ((ex.br_op == rv_pkg::br_jump) && !ex.sel_pc) begin
            redirect_pc_o = {alu_res[XLEN-1:1], 1'b0};
        end else begin
            redirect_pc_o = pc_imm;
        end
    end

    assign flush_o   = ex.valid && taken;  // also redirect
    assign wb_en_o   = ex.valid && ex.wr_en && (ex.rd != 5'd0);
    assign wb_addr_o = ex.rd;
    assign wb_data_o = (ex.wb_sel == rv_pkg::wb_link) ? link : alu_res;

endmodule

// ==== source/rv_id_ex.sv ====
`timescale 1ns/1ps

module rv_id_ex #(
    parameter int XLEN = 64
) (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          bubble_i,
    input  logic          flush_i,
    id_ex_if.reg_in_mp    d_in,
    id_ex_if.reg_out_mp   d_out
);

    always_ff @(posedge clk) begin
        if (reset_i || bubble_i || flush_i) begin  // empty slot
            d_out.valid   <= 1'b0;
            d_out.alu_op  <= rv_pkg::alu_add;
            d_out.br_op   <= rv_pkg::br_none;
            d_out.wb_sel  <= rv_pkg::wb_alu;
            d_out.sel_imm <= 1'b0;
            d_out.sel_pc  <= 1'b0;
            d_out.rd      <= 5'd0;
            d_out.wr_en   <= 1'b0;
            d_out.rs1_val <= {XLEN{1'b0}};
            d_out.rs2_val <= {XLEN{1'b0}};
            d_out.imm     <= {XLEN{1'b0}};
            d_out.pc      <= {XLEN{1'b0}};
        end else begin
            d_out.valid   <= d_in.valid;
            d_out.alu_op  <= d_in.alu_op;
            d_out.br_op   <= d_in.br_op;
            d_out.wb_sel  <= d_in.wb_sel;
            d_out.sel_imm <= d_in.sel_imm;
            d_out.sel_pc  <= d_in.sel_pc;
            d_out.rd      <= d_in.rd;
            d_out.wr_en   <= d_in.wr_en;
            d_out.rs1_val <= d_in.rs1_val;
            d_out.rs2_val <= d_in.rs2_val;
            d_out.imm     <= d_in.imm;
            d_out.pc      <= d_in.pc;
        end
    end

endmodule

// ==== source/rv_pkg.sv ====
package rv_pkg;

    // major opcodes handled by the slice
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011,
        lui    = 7'b0110111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_pass_b = 3'd5  // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none = 2'd0,
        br_beq  = 2'd1,
        br_bne  = 2'd2,
        br_jump = 2'd3  // jal and jalr
    } br_op_e;

    typedef enum logic {
        wb_alu  = 1'b0,
        wb_link = 1'b1  // pc + 4
    } wb_sel_e;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [6:0] f7_base    = 7'b0000000;
    localparam logic [6:0] f7_alt     = 7'b0100000;  // sub

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } instr_i_t;

    // same 32-bit word, two field layouts
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  logic            wr_en_i,
    input  logic [4:0]      wr_addr_i,
    input  logic [XLEN-1:0] wr_data_i
);

    logic [XLEN-1:0] regs [1:31];  // x0 not stored

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != 5'd0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 20,
    parameter int reset_cycles = 5
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(half_period) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    localparam int period_ns = 40;
    localparam int n_instr   = 1 + 32 + 5 + 10 + 8 + 5 + 1;  // sum over all tests

    logic        clk;
    logic        reset_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [63:0] pc_i;
    logic        redirect_o;
    logic [63:0] redirect_pc_o;
    logic        wb_en_o;
    logic [4:0]  wb_addr_o;
    logic [63:0] wb_data_o;

    logic [63:0] model [0:31];  // architectural registers
    logic [63:0] cur_pc;
    logic [31:0] rng_state = 32'h00aba901;
    logic        exp_wb_en;
    logic [4:0]  exp_wb_addr;
    logic [63:0] exp_wb_data;
    logic        exp_redir;
    logic [63:0] exp_redir_pc;

    tb_clock_gen #(.half_period(period_ns / 2), .reset_cycles(5)) i_clock_gen (
        .clk_o   (clk),
        .reset_o (reset_i)
    );

    rv_core_top #(.XLEN(64)) i_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .wb_en_o       (wb_en_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [4:0] rand_reg();  // x1 .. x31
        return 5'(((lcg_next() >> 16) % 31) + 1);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s got %h, expected %h", $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // reference model of one instruction, ISA field positions
    task automatic predict(input logic v, input logic [31:0] w, input logic [63:0] pc);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] imm_i;
        logic [63:0] res;
        logic        ok;
        logic        wr;
        f3 = w[14:12];
        f7 = w[31:25];
        a = model[w[19:15]];
        b = model[w[24:20]];
        imm_i = {{52{w[31]}}, w[31:20]};
        ok = 1'b0;
        wr = 1'b0;
        res = '0;
        exp_redir = 1'b0;
        exp_redir_pc = '0;
        case (w[6:0])
            7'h13: begin
                ok = 1'b1;
                wr = 1'b1;
                case (f3)
                    3'd0: res = a + imm_i;
                    3'd4: res = a ^ imm_i;
                    3'd6: res = a | imm_i;
                    3'd7: res = a & imm_i;
                    default: ok = 1'b0;
                endcase
            end
            7'h33: begin
                ok = 1'b1;
                wr = 1'b1;
                if (f7 == 7'h20 && f3 == 3'd0) res = a - b;
                else if (f7 == 7'h00 && f3 == 3'd0) res = a + b;
                else if (f7 == 7'h00 && f3 == 3'd4) res = a ^ b;
                else if (f7 == 7'h00 && f3 == 3'd6) res = a | b;
                else if (f7 == 7'h00 && f3 == 3'd7) res = a & b;
                else ok = 1'b0;
            end
            7'h37: begin
                ok = 1'b1;
                wr = 1'b1;
                res = {{32{w[31]}}, w[31:12], 12'h000};
            end
            7'h6f: begin
                ok = 1'b1;
                wr = 1'b1;
                res = pc + 64'd4;
                exp_redir = 1'b1;
                exp_redir_pc = pc + {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                ok = (f3 == 3'd0);
                wr = 1'b1;
                res = pc + 64'd4;
                exp_redir = 1'b1;
                exp_redir_pc = (a + imm_i) & ~64'd1;
            end
            7'h63: begin
                ok = (f3 == 3'd0) || (f3 == 3'd1);
                exp_redir = (f3 == 3'd0) ? (a == b) : (a != b);
                exp_redir_pc = pc + {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            default: ok = 1'b0;
        endcase
        exp_redir   = exp_redir && v && ok;
        exp_wb_en   = wr && v && ok && (w[11:7] != 5'd0);
        exp_wb_addr = w[11:7];
        exp_wb_data = res;
    endtask

    // present one slot, then check the slot before it, now in execute
    task automatic issue(input logic v, input logic [31:0] w);
        logic [63:0] this_pc;
        this_pc = cur_pc;
        @(posedge clk);
        instr_valid_i <= v;
        instr_i       <= w;
        pc_i          <= this_pc;
        @(negedge clk);
        check(wb_en_o, exp_wb_en, "wb_en_o");
        if (exp_wb_en) begin
            check(wb_addr_o, exp_wb_addr, "wb_addr_o");
            check(wb_data_o, exp_wb_data, "wb_data_o");
            model[exp_wb_addr] = exp_wb_data;
        end
        check(redirect_o, exp_redir, "redirect_o");
        if (exp_redir) begin
            check(redirect_pc_o, exp_redir_pc, "redirect_pc_o");
            cur_pc = exp_redir_pc;  // caller follows the redirect
        end else begin
            cur_pc = this_pc + 64'd4;
        end
        predict(v && !exp_redir, w, this_pc);  // younger slot squashed
    endtask

    task automatic test_reset();
        do begin
            @(negedge clk);
            check(wb_en_o, 1'b0, "wb_en_o in reset");
            check(redirect_o, 1'b0, "redirect_o in reset");
        end while (reset_i);
        issue(1'b1, enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));  // add x3, x1, x2
    endtask

    task automatic test_alu();
        logic [4:0]  rd;
        logic [31:0] r;
        for (int n = 0; n < 8; n++) begin
            rd = rand_reg();
            issue(1'b1, {20'(lcg_next() >> 12), rd, 7'h37});
            issue(1'b1, enc_i(12'(lcg_next() >> 20), rd, 3'd0, rd, 7'h13));
        end
        for (int n = 0; n < 16; n++) begin
            r = lcg_next();
            case (n % 9)
                0: issue(1'b1, enc_r(7'h00, rand_reg(), rand_reg(), 3'd0, rand_reg()));
                1: issue(1'b1, enc_r(7'h20, rand_reg(), rand_reg(), 3'd0, rand_reg()));
                2: issue(1'b1, enc_r(7'h00, rand_reg(), rand_reg(), 3'd7, rand_reg()));
                3: issue(1'b1, enc_r(7'h00, rand_reg(), rand_reg(), 3'd6, rand_reg()));
                4: issue(1'b1, enc_r(7'h00, rand_reg(), rand_reg(), 3'd4, rand_reg()));
                5: issue(1'b1, enc_i(r[11:0], rand_reg(), 3'd0, rand_reg(), 7'h13));
                6: issue(1'b1, enc_i(r[11:0], rand_reg(), 3'd7, rand_reg(), 7'h13));
                7: issue(1'b1, enc_i(r[11:0], rand_reg(), 3'd6, rand_reg(), 7'h13));
                default: issue(1'b1, enc_i(r[11:0], rand_reg(), 3'd4, rand_reg(), 7'h13));
            endcase
        end
    endtask

    task automatic test_bypass();
        issue(1'b1, enc_i(12'hfa5, 5'd0, 3'd0, 5'd5, 7'h13));  // negative imm
        issue(1'b1, enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
        issue(1'b1, enc_r(7'h20, 5'd5, 5'd6, 3'd0, 5'd7));
        issue(1'b1, enc_i(12'd5, 5'd7, 3'd4, 5'd0, 7'h13));   // rd x0, no write
        issue(1'b1, enc_r(7'h00, 5'd7, 5'd0, 3'd0, 5'd8));
    endtask

    task automatic test_branch();
        issue(1'b1, enc_i(12'd100, 5'd0, 3'd0, 5'd10, 7'h13));
        issue(1'b1, enc_i(12'd100, 5'd0, 3'd0, 5'd11, 7'h13));
        issue(1'b1, enc_b(13'd64, 5'd11, 5'd10, 3'd0));       // beq taken
        issue(1'b1, enc_i(12'd1, 5'd0, 3'd0, 5'd12, 7'h13));
        issue(1'b1, enc_i(12'd2, 5'd0, 3'd0, 5'd13, 7'h13));
        issue(1'b1, enc_b(13'd32, 5'd11, 5'd10, 3'd1));       // bne not taken
        issue(1'b1, enc_i(12'd3, 5'd0, 3'd0, 5'd14, 7'h13));
        issue(1'b1, enc_b(13'h1ff0, 5'd0, 5'd10, 3'd1));      // back by 16
        issue(1'b1, enc_i(12'd4, 5'd0, 3'd0, 5'd15, 7'h13));
        issue(1'b1, enc_i(12'd5, 5'd0, 3'd0, 5'd15, 7'h13));
    endtask

    task automatic test_jump();
        issue(1'b1, enc_j(21'd128, 5'd1));
        issue(1'b1, enc_i(12'd7, 5'd0, 3'd0, 5'd2, 7'h13));
        issue(1'b1, enc_i(12'h033, 5'd0, 3'd0, 5'd3, 7'h13));
        issue(1'b1, enc_i(12'd6, 5'd3, 3'd0, 5'd4, 7'h67));   // odd target
        issue(1'b1, enc_i(12'd1, 5'd0, 3'd0, 5'd5, 7'h13));
        issue(1'b1, enc_j(21'h1ffff8, 5'd0));
        issue(1'b1, enc_i(12'd9, 5'd0, 3'd0, 5'd5, 7'h13));
        issue(1'b1, enc_i(12'd1, 5'd1, 3'd0, 5'd6, 7'h13));
    endtask

    task automatic test_empty();
        issue(1'b0, enc_i(12'd1, 5'd0, 3'd0, 5'd9, 7'h13));
        issue(1'b1, {25'h0, 5'd9, 7'h03});                    // load
        issue(1'b1, enc_i(12'd3, 5'd1, 3'd1, 5'd9, 7'h13));   // slli
        issue(1'b1, enc_r(7'h20, 5'd2, 5'd1, 3'd6, 5'd9));
        issue(1'b0, enc_b(13'd8, 5'd0, 5'd0, 3'd0));
    endtask

    initial begin
        instr_valid_i <= 1'b0;
        instr_i       <= 32'h0;
        pc_i          <= 64'h0;
        for (int n = 0; n < 32; n++) begin
            model[n] = '0;
        end
        cur_pc = 64'h1000;
        exp_wb_en = 1'b0;
        exp_wb_addr = '0;
        exp_wb_data = '0;
        exp_redir = 1'b0;
        exp_redir_pc = '0;
        test_reset();
        test_alu();
        test_bypass();
        test_branch();
        test_jump();
        test_empty();
        issue(1'b0, 32'h0);  // drain the last slot
        $display("*** TEST PASSED ***");
        $finish;
    end

    initial begin
        #((n_instr + 50) * period_ns);
        $display("watchdog expired, the run hung before all tests finished");
        $display("*** TEST FAILED ***");
        $fatal(1);
    end

endmodule
